// File: design/switch_defines.svh
`ifndef SWITCH_DEFINES_SVH
`define SWITCH_DEFINES_SVH

// switch ports
`define NUM_PORTS 4

// mac table index width, 64 entries
`define TABLE_BITS 6

// egress queue depth in bytes, power of two
`define QUEUE_DEPTH 256

// bytes captured before the lookup (dmac + smac)
`define HDR_BYTES 12

`endif

// File: design/switch_pkg.sv
`default_nettype none
`include "switch_defines.svh"

package switch_pkg;

	typedef logic [7:0] byte_t;

	typedef logic [47:0] mac_t;

	typedef logic [1:0] port_t;

	typedef logic [`NUM_PORTS-1:0] portmap_t; // one bit per port

	typedef logic [`TABLE_BITS-1:0] hash_t;

	typedef enum logic [2:0] {
		IDLE,
		HEADER,
		LOOKUP,
		REPLAY,
		BODY,
		DROP
	} parse_state_t;

endpackage

`default_nettype wire

// File: design/frame_if.sv
`timescale 1ns/1ps
`default_nettype none

// byte stream, one byte per valid/ready handshake
interface frame_if;
	logic valid;
	logic ready;
	switch_pkg::byte_t data;
	logic last; // marks the final byte of a frame

	modport src (output valid, output data, output last, input ready);
	modport dst (input valid, input data, input last, output ready);
endinterface

// parser to mac table, req held until ack
interface lookup_if;
	logic req;
	logic ack;
	switch_pkg::mac_t dmac;
	switch_pkg::mac_t smac;
	switch_pkg::port_t src_port;
	switch_pkg::portmap_t portmap; // valid while ack is high

	modport requester (
		output req,
		output dmac,
		output smac,
		output src_port,
		input ack,
		input portmap
	);
	modport rsp (
		input req,
		input dmac,
		input smac,
		input src_port,
		output ack,
		output portmap
	);
endinterface

`default_nettype wire

// File: design/port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "switch_defines.svh"

module port_arbiter (
	input wire clk,
	input wire arst_n,
	input wire switch_pkg::portmap_t rx_valid,
	output switch_pkg::portmap_t rx_ready,
	input wire switch_pkg::byte_t rx_data [`NUM_PORTS],
	input wire switch_pkg::portmap_t rx_last,
	frame_if.src out,
	output switch_pkg::port_t src_port
);

	logic busy; // a frame is granted
	switch_pkg::port_t grant; // current or last granted port
	switch_pkg::port_t pick;
	switch_pkg::port_t idx;
	logic found;

	// first valid port after the last grant
	always_comb begin
		pick = grant;
		idx = grant;
		found = 1'b0;
		for (int i = 1; i <= `NUM_PORTS; i++) begin
			idx = switch_pkg::port_t'(grant + i);
			if (!found && rx_valid[idx]) begin
				pick = idx;
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			grant <= switch_pkg::port_t'(`NUM_PORTS - 1); // port 0 searched first
		end else if (!busy) begin
			if (found) begin
				busy <= 1'b1;
				grant <= pick;
			end
		end else if (out.valid && out.ready && out.last) begin
			busy <= 1'b0; // released after the last byte
		end
	end

	assign out.valid = busy & rx_valid[grant];
	assign out.data = rx_data[grant];
	assign out.last = rx_last[grant];
	assign src_port = grant;

	// back-pressure goes to the granted port only
	always_comb begin
		rx_ready = '0;
		rx_ready[grant] = busy & out.ready;
	end

endmodule

`default_nettype wire

// File: design/frame_parser.sv
`timescale 1ns/1ps
`default_nettype none
`include "switch_defines.svh"

module frame_parser (
	input wire clk,
	input wire arst_n,
	frame_if.dst in,
	input wire switch_pkg::port_t src_port,
	lookup_if.requester lkp,
	output switch_pkg::portmap_t wr,
	output switch_pkg::byte_t wr_data,
	output logic wr_last,
	input wire switch_pkg::portmap_t space
);

	localparam int HDR_W = `HDR_BYTES * 8;
	localparam int MAC_W = $bits(switch_pkg::mac_t);
	localparam int CNT_W = $clog2(`HDR_BYTES);
	localparam logic [CNT_W-1:0] HDR_END = CNT_W'(`HDR_BYTES - 1);

	switch_pkg::parse_state_t state;
	logic [HDR_W-1:0] hdr; // first byte sits at the top
	logic [CNT_W-1:0] cnt;
	switch_pkg::portmap_t map;
	logic req;
	logic ok;
	logic take;

	// every queue of the frame has room
	assign ok = &(space | ~map);
	assign take = in.valid & in.ready;

	assign lkp.req = req;
	assign lkp.dmac = hdr[HDR_W-1 -: MAC_W];
	assign lkp.smac = hdr[HDR_W-MAC_W-1 -: MAC_W];
	assign lkp.src_port = src_port;

	always_comb begin
		in.ready = 1'b0;
		wr = '0;
		wr_data = in.data;
		wr_last = in.last;
		case (state)
			switch_pkg::HEADER: in.ready = 1'b1;
			switch_pkg::REPLAY: begin
				wr = ok ? map : '0;
				wr_data = hdr[HDR_W-1 -: 8];
				wr_last = 1'b0; // header never ends a frame here
			end
			switch_pkg::BODY: begin
				in.ready = ok;
				wr = (ok && in.valid) ? map : '0;
			end
			switch_pkg::DROP: in.ready = 1'b1; // swallow the rest
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= switch_pkg::IDLE;
			cnt <= '0;
			req <= 1'b0;
			map <= '0;
		end else begin
			case (state)
				switch_pkg::IDLE: begin
					cnt <= '0;
					if (in.valid)
						state <= switch_pkg::HEADER;
				end
				switch_pkg::HEADER: begin
					if (take) begin
						cnt <= cnt + 1'b1;
						if (in.last) begin
							state <= switch_pkg::IDLE; // runt, no lookup
						end else if (cnt == HDR_END) begin
							state <= switch_pkg::LOOKUP;
							req <= 1'b1;
						end
					end
				end
				switch_pkg::LOOKUP: begin
					if (lkp.ack) begin
						req <= 1'b0;
						map <= lkp.portmap;
						cnt <= '0;
						if (lkp.portmap == '0)
							state <= switch_pkg::DROP;
						else
							state <= switch_pkg::REPLAY;
					end
				end
				switch_pkg::REPLAY: begin
					if (ok) begin
						cnt <= cnt + 1'b1;
						if (cnt == HDR_END)
							state <= switch_pkg::BODY;
					end
				end
				switch_pkg::BODY, switch_pkg::DROP: begin
					if (take && in.last)
						state <= switch_pkg::IDLE;
				end
				default: state <= switch_pkg::IDLE;
			endcase
		end
	end

	// shift in on capture, shift out on replay
	always_ff @(posedge clk) begin
		if (state == switch_pkg::HEADER && take)
			hdr <= {hdr[HDR_W-9:0], in.data};
		else if (state == switch_pkg::REPLAY && ok)
			hdr <= hdr << 8;
	end

endmodule

`default_nettype wire

// File: design/mac_table.sv
`timescale 1ns/1ps
`default_nettype none
`include "switch_defines.svh"

module mac_table (
	input wire clk,
	input wire arst_n,
	lookup_if.rsp lkp
);

	localparam int ENTRIES = 1 << `TABLE_BITS;
	localparam int SLICES = $bits(switch_pkg::mac_t) / `TABLE_BITS;

	logic [ENTRIES-1:0] ent_valid;
	switch_pkg::mac_t ent_mac [ENTRIES];
	switch_pkg::port_t ent_port [ENTRIES];

	switch_pkg::hash_t d_hash;
	switch_pkg::hash_t s_hash;
	logic start;
	logic busy; // entry read, learn pending
	logic ack;
	switch_pkg::portmap_t portmap;
	logic rd_valid;
	switch_pkg::mac_t rd_mac;
	switch_pkg::port_t rd_port;
	logic hit;
	switch_pkg::portmap_t flood;

	// xor of the 6-bit slices
	function automatic switch_pkg::hash_t mac_hash(input switch_pkg::mac_t mac);
		switch_pkg::hash_t h;
		h = '0;
		for (int i = 0; i < SLICES; i++) begin
			h ^= mac[i*`TABLE_BITS +: `TABLE_BITS];
		end
		return h;
	endfunction

	assign d_hash = mac_hash(lkp.dmac);
	assign s_hash = mac_hash(lkp.smac);

	// req stays high through ack, so ignore it then
	assign start = lkp.req & ~busy & ~ack;

	assign hit = rd_valid && (rd_mac == lkp.dmac);
	assign flood = ~(switch_pkg::portmap_t'(1) << lkp.src_port); // all but ingress

	assign lkp.ack = ack;
	assign lkp.portmap = portmap;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			ack <= 1'b0;
			rd_valid <= 1'b0;
			ent_valid <= '0;
		end else begin
			busy <= start;
			ack <= busy;
			if (start)
				rd_valid <= ent_valid[d_hash];
			if (busy)
				ent_valid[s_hash] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			rd_mac <= ent_mac[d_hash]; // state before this frame's learn
			rd_port <= ent_port[d_hash];
		end
		if (busy) begin
			ent_mac[s_hash] <= lkp.smac; // overwrite on collision
			ent_port[s_hash] <= lkp.src_port;
			if (&lkp.dmac || !hit)
				portmap <= flood;
			else if (rd_port == lkp.src_port)
				portmap <= '0; // stays on the ingress segment
			else
				portmap <= switch_pkg::portmap_t'(1) << rd_port;
		end
	end

endmodule

`default_nettype wire

// File: design/egress_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "switch_defines.svh"

module egress_queue (
	input wire clk,
	input wire arst_n,
	input wire wr,
	input wire switch_pkg::byte_t wr_data,
	input wire wr_last,
	output logic space,
	output logic tx_valid,
	input wire tx_ready,
	output switch_pkg::byte_t tx_data,
	output logic tx_last
);

	localparam int AW = $clog2(`QUEUE_DEPTH);
	localparam logic [AW:0] FULL = (AW + 1)'(`QUEUE_DEPTH);

	logic [8:0] mem [`QUEUE_DEPTH]; // {last, byte}
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic push;
	logic pop;

	assign space = (count != FULL);
	assign tx_valid = (count != '0);
	assign {tx_last, tx_data} = mem[rd_ptr]; // head word shows through
	assign push = wr & space;
	assign pop = tx_valid & tx_ready;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= {wr_last, wr_data};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/switch_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "switch_defines.svh"

module switch_core (
	input wire clk,
	input wire arst_n,
	input wire switch_pkg::portmap_t rx_valid,
	output wire switch_pkg::portmap_t rx_ready,
	input wire switch_pkg::byte_t rx_data [`NUM_PORTS],
	input wire switch_pkg::portmap_t rx_last,
	output wire switch_pkg::portmap_t tx_valid,
	input wire switch_pkg::portmap_t tx_ready,
	output wire switch_pkg::byte_t tx_data [`NUM_PORTS],
	output wire switch_pkg::portmap_t tx_last
);

	frame_if rx_stream ();
	lookup_if lkp_bus ();

	switch_pkg::port_t src_port;
	switch_pkg::portmap_t wr; // write strobe per egress queue
	switch_pkg::byte_t wr_data;
	logic wr_last;
	wire switch_pkg::portmap_t space;

	port_arbiter u_arbiter (
		.clk(clk),
		.arst_n(arst_n),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready),
		.rx_data(rx_data),
		.rx_last(rx_last),
		.out(rx_stream.src),
		.src_port(src_port)
	);

	frame_parser u_parser (
		.clk(clk),
		.arst_n(arst_n),
		.in(rx_stream.dst),
		.src_port(src_port),
		.lkp(lkp_bus.requester),
		.wr(wr),
		.wr_data(wr_data),
		.wr_last(wr_last),
		.space(space)
	);

	mac_table u_table (
		.clk(clk),
		.arst_n(arst_n),
		.lkp(lkp_bus.rsp)
	);

	// one queue per transmit port, all fed from the parser
	for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_egress
		egress_queue u_queue (
			.clk(clk),
			.arst_n(arst_n),
			.wr(wr[i]),
			.wr_data(wr_data),
			.wr_last(wr_last),
			.space(space[i]),
			.tx_valid(tx_valid[i]),
			.tx_ready(tx_ready[i]),
			.tx_data(tx_data[i]),
			.tx_last(tx_last[i])
		);
	end

endmodule

`default_nettype wire

// File: test/tb_switch_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "switch_defines.svh"

module tb_switch_core;

	localparam int MAX_FRAMES = 64;
	localparam int GROUP_TIMEOUT = 20000; // cycles
	localparam int DRAIN_CYCLES = 300;

	logic clk;
	logic arst_n;
	switch_pkg::portmap_t rx_valid;
	wire switch_pkg::portmap_t rx_ready;
	switch_pkg::byte_t rx_data [`NUM_PORTS];
	switch_pkg::portmap_t rx_last;
	wire switch_pkg::portmap_t tx_valid;
	switch_pkg::portmap_t tx_ready;
	wire switch_pkg::byte_t tx_data [`NUM_PORTS];
	wire switch_pkg::portmap_t tx_last;

	int f_group [MAX_FRAMES];
	int f_port [MAX_FRAMES];
	switch_pkg::mac_t f_dmac [MAX_FRAMES];
	switch_pkg::mac_t f_smac [MAX_FRAMES];
	int f_len [MAX_FRAMES];
	switch_pkg::portmap_t f_mask [MAX_FRAMES];
	int n_frames;
	int last_grant; // arbiter model
	logic [8:0] drive_q [`NUM_PORTS][$]; // {last, byte}
	logic [8:0] exp_q [`NUM_PORTS][$];

	switch_core DUT (.*);

	always #10 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_byte(input string name, input switch_pkg::byte_t got,
			input switch_pkg::byte_t exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED time %0t %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_last(input string name, input bit got, input bit exp);
		if (got != exp)
			abort_run($sformatf("CHECK FAILED time %0t %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic read_frames();
		int fd;
		int n;
		string line;
		n_frames = 0;
		fd = $fopen("test/switch_input.txt", "r");
		if (fd == 0)
			abort_run("cannot open test/switch_input.txt");
		while (!$feof(fd) && n_frames < MAX_FRAMES) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() != 0 && line[0] != "#") begin
				n = $sscanf(line, "%d %d %h %h %d %h", f_group[n_frames], f_port[n_frames],
					f_dmac[n_frames], f_smac[n_frames], f_len[n_frames], f_mask[n_frames]);
				if (n == 6)
					n_frames++;
			end
		end
		$fclose(fd);
		if (n_frames == 0)
			abort_run("no frames found in test/switch_input.txt");
	endtask

	// queue a group in grant order starting after the last grant
	task automatic launch_group(input int first, input int stop, output int expected);
		int i;
		int p;
		int k;
		int b;
		int q;
		int base;
		logic [`HDR_BYTES*8-1:0] hdr;
		logic [8:0] w;
		expected = 0;
		base = last_grant;
		for (i = 1; i <= `NUM_PORTS; i++) begin
			p = (base + i) % `NUM_PORTS;
			for (k = first; k < stop; k++) begin
				if (f_port[k] == p) begin
					last_grant = p;
					hdr = {f_dmac[k], f_smac[k]};
					for (b = 0; b < f_len[k]; b++) begin
						if (b < `HDR_BYTES)
							w[7:0] = hdr[8*(`HDR_BYTES-1-b) +: 8];
						else
							w[7:0] = switch_pkg::byte_t'($urandom);
						w[8] = (b == f_len[k] - 1);
						drive_q[p].push_back(w);
						for (q = 0; q < `NUM_PORTS; q++)
							if (f_mask[k][q])
								exp_q[q].push_back(w);
					end
					expected += f_len[k] * $countones(f_mask[k]);
				end
			end
		end
	endtask

	function automatic bit group_done();
		bit done;
		done = (rx_valid == '0);
		for (int p = 0; p < `NUM_PORTS; p++)
			if (drive_q[p].size() != 0 || exp_q[p].size() != 0)
				done = 1'b0;
		return done;
	endfunction

	task automatic wait_group(input int grp, input int expected);
		int cycles;
		cycles = 0;
		while (!group_done()) begin
			@(negedge clk);
			cycles++;
			if (cycles > GROUP_TIMEOUT)
				abort_run($sformatf("group %0d did not drain in %0d cycles", grp, cycles));
		end
		cycles = 0;
		while (expected == 0 && cycles < DRAIN_CYCLES) begin // nothing expected so watch for strays
			@(negedge clk);
			cycles++;
		end
	endtask

	for (genvar g = 0; g < `NUM_PORTS; g++) begin : g_port
		// holds a byte until the switch takes it
		always @(posedge clk) begin
			if (rx_valid[g] && rx_ready[g])
				void'(drive_q[g].pop_front());
			if (drive_q[g].size() != 0) begin
				rx_valid[g] <= 1'b1;
				rx_data[g] <= drive_q[g][0][7:0];
				rx_last[g] <= drive_q[g][0][8];
			end else begin
				rx_valid[g] <= 1'b0;
			end
		end

		always @(posedge clk) begin : mon
			logic [8:0] word;
			if (tx_valid[g] && tx_ready[g]) begin
				if (exp_q[g].size() == 0) begin
					abort_run($sformatf("transmit port %0d sent a byte no frame accounts for", g));
				end else begin
					word = exp_q[g].pop_front();
					check_byte($sformatf("tx_data[%0d]", g), tx_data[g], word[7:0]);
					check_last($sformatf("tx_last[%0d]", g), tx_last[g], word[8]);
				end
			end
			tx_ready[g] <= ($urandom % 4) != 0; // throttle about a quarter of cycles
		end
	end

	initial begin
		int idx;
		int first;
		int expected;
		void'($urandom(14532));
		clk = 1'b0;
		arst_n = 1'b0;
		rx_valid = '0;
		rx_last = '0;
		tx_ready = '0;
		for (int p = 0; p < `NUM_PORTS; p++)
			rx_data[p] = '0;
		last_grant = `NUM_PORTS - 1; // port 0 first after reset
		read_frames();
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		idx = 0;
		while (idx < n_frames) begin
			first = idx;
			while (idx < n_frames && f_group[idx] == f_group[first])
				idx++;
			@(negedge clk);
			launch_group(first, idx, expected);
			wait_group(f_group[first], expected);
		end
		if (tx_valid != '0) begin
			abort_run("transmit side still holds bytes after the last group");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: test/switch_input.txt
# group port dmac smac length mask (port, length decimal; macs, mask hex)
# one group starts together; mask bit n expects a copy on transmit port n
0 0 ffffffffffff 020000000001 20 e
1 1 020000000009 020000000002 30 d
2 2 020000000001 020000000003 40 1
3 0 020000000002 020000000001 28 2
4 0 020000000001 020000000004 32 0
5 3 020000000003 020000000001 25 4
6 2 020000000001 020000000003 36 8
7 1 ffffffffffff 060000000000 22 d
8 2 020000000001 020000000003 27 b
9 0 060000000000 020000000004 31 2
10 0 ffffffffffff 020000000004 16 e
10 1 ffffffffffff 020000000002 24 d
10 2 ffffffffffff 020000000003 20 b
10 3 ffffffffffff 020000000005 18 7
11 3 020000000002 020000000006 10 0
11 0 020000000002 020000000007 12 0
12 2 020000000006 020000000003 33 b
13 1 020000000005 020000000002 45 8
13 3 020000000002 020000000005 50 2
13 0 020000000002 020000000004 60 2
14 1 ffffffffffff 020000000002 200 d
15 3 020000000001 020000000007 22 7
16 0 020000000007 020000000004 13 8

// File: verilog.f
+incdir+design
design/switch_pkg.sv
design/frame_if.sv
design/port_arbiter.sv
design/frame_parser.sv
design/mac_table.sv
design/egress_queue.sv
design/switch_core.sv
test/tb_switch_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_switch_core
LINT_TOP ?= switch_core
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
EXE ?= sim_switch
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

SRCS := $(wildcard design/*.sv design/*.svh test/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/$(EXE)

$(BUILD_DIR)/$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(EXE)

run: build
	-./$(BUILD_DIR)/$(EXE) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
